// File: aes.f
+incdir+verification
source/aes_pkg.sv
source/aes_sbox.sv
source/aes_control.sv
source/aes_key_expand.sv
source/aes_round.sv
source/aes_core.sv
source/aes_spi.sv
source/aes.sv
verification/aes_tb.sv

// File: run.sh
#!/bin/sh
# build the AES testbench with Verilator and run it
# the exit status of the simulation is the result
set -e

cd "$(dirname "$0")"

verilator --binary --assert -f aes.f --top-module aes_tb -o aes_tb_sim

./obj_dir/aes_tb_sim

// File: source/aes.sv
////////////////////////////////////////
// serial AES-128 encryptor
// shift in plaintext then key, drop load, wait done
////////////////////////////////////////

module aes (
	input logic clk,
	input logic reset,
	input logic sck,
	input logic sdi,
	input logic load,
	output logic sdo,
	output logic done
);

	aes_pkg::block_t plaintext;
	aes_pkg::block_t key;
	aes_pkg::block_t ciphertext;

	// sck domain shift registers
	aes_spi i_spi (
		.sck(sck),
		.sdi(sdi),
		.load(load),
		.done(done),
		.ciphertext(ciphertext),
		.plaintext(plaintext),
		.key(key),
		.sdo(sdo)
	);

	// clk domain cipher
	aes_core i_core (
		.clk(clk),
		.reset(reset),
		.load(load),
		.plaintext(plaintext),
		.key(key),
		.ciphertext(ciphertext),
		.done(done)
	);

endmodule

// File: source/aes_control.sv
////////////////////////////////////////
// start is load seen low after being seen high
// one block at a time; done holds until load rises
////////////////////////////////////////

module aes_control (
	input logic clk,
	input logic reset,
	input logic load,
	output logic capture,
	output logic step,
	output aes_pkg::round_t round,
	output logic last_round,
	output logic done_load,
	output logic done
);

	logic load_prev;
	logic start;
	// phase: high from capture through the last round's step
	logic running;
	// second cycle of the round
	logic half;

	// falling edge of load in clk time
	assign start = load_prev && !load;

	assign step = running && half;
	assign last_round = (round == aes_pkg::round_t'(aes_pkg::NUM_ROUNDS));

	////////////////////////////////////////
	// sequencing
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			load_prev <= 1'b0;
			capture <= 1'b0;
			running <= 1'b0;
			half <= 1'b0;
			round <= '0;
			done_load <= 1'b0;
			done <= 1'b0;
		end else begin
			load_prev <= load;
			// one strobe per start, datapaths load on the next edge
			capture <= start;
			// final AddRoundKey happens the cycle after the last step
			done_load <= step && last_round;

			if (capture) begin
				running <= 1'b1;
				half <= 1'b0;
				round <= 4'd1;
			end else if (running) begin
				half <= !half;
				if (step) begin
					if (last_round)
						running <= 1'b0;
					else
						round <= round + 4'd1;
				end
			end

			// raising load releases the ciphertext
			if (load)
				done <= 1'b0;
			else if (done_load)
				done <= 1'b1;
		end
	end

	////////////////////////////////////////
	// checks
	////////////////////////////////////////

	done_not_running: assert property (@(posedge clk) disable iff (reset) done |-> !running)
		else $error("done high while rounds still running");

	round_in_range: assert property (@(posedge clk) disable iff (reset)
		round <= aes_pkg::round_t'(aes_pkg::NUM_ROUNDS))
		else $error("round counter past last round");

endmodule

// File: source/aes_core.sv
////////////////////////////////////////
// iterative AES-128 encrypt, done 22 clks after start
// plaintext and key must hold until capture
////////////////////////////////////////

module aes_core (
	input logic clk,
	input logic reset,
	input logic load,
	input aes_pkg::block_t plaintext,
	input aes_pkg::block_t key,
	output aes_pkg::block_t ciphertext,
	output logic done
);

	logic capture;
	logic step;
	logic last_round;
	logic done_load;
	aes_pkg::round_t round;
	// key for the round in progress
	aes_pkg::block_t round_key;

	// sequencing for both datapaths
	aes_control i_control (
		.clk(clk),
		.reset(reset),
		.load(load),
		.capture(capture),
		.step(step),
		.round(round),
		.last_round(last_round),
		.done_load(done_load),
		.done(done)
	);

	// key schedule runs in lockstep with the state
	aes_key_expand i_key_expand (
		.clk(clk),
		.reset(reset),
		.capture(capture),
		.step(step),
		.round(round),
		.key(key),
		.round_key(round_key)
	);

	aes_round i_round (
		.clk(clk),
		.reset(reset),
		.capture(capture),
		.step(step),
		.last_round(last_round),
		.plaintext(plaintext),
		.round_key(round_key),
		.ciphertext(ciphertext),
		.done_load(done_load)
	);

endmodule

// File: source/aes_key_expand.sv
////////////////////////////////////////
// on-the-fly key schedule, one round key held
// S-box output must be one cycle old before step
////////////////////////////////////////

module aes_key_expand (
	input logic clk,
	input logic reset,
	input logic capture,
	input logic step,
	input aes_pkg::round_t round,
	input aes_pkg::block_t key,
	output aes_pkg::block_t round_key
);

	aes_pkg::word_t rot_word;
	aes_pkg::word_t sub_word;
	aes_pkg::word_t rcon;
	aes_pkg::word_t temp;
	aes_pkg::word_t w0;
	aes_pkg::word_t w1;
	aes_pkg::word_t w2;
	aes_pkg::word_t w3;
	aes_pkg::block_t next_key;

	// RotWord on the last column, bytes move up by one
	assign rot_word = {round_key[23:0], round_key[31:24]};

	// SubWord, ready in the round's second cycle
	aes_sbox #(
		.NUM_BYTES(4)
	) i_sbox (
		.clk(clk),
		.in_bytes(rot_word),
		.out_bytes(sub_word)
	);

	// no constant before the first round
	assign rcon = (round != '0) ? aes_pkg::RCON[round] : '0;
	assign temp = sub_word ^ rcon;

	// each new word chains off the one before it
	always_comb begin
		w0 = round_key[127:96] ^ temp;
		w1 = round_key[95:64] ^ w0;
		w2 = round_key[63:32] ^ w1;
		w3 = round_key[31:0] ^ w2;
		next_key = {w0, w1, w2, w3};
	end

	// round key register
	always_ff @(posedge clk) begin
		if (capture)
			round_key <= key;
		else if (step)
			round_key <= next_key;
	end

	// step only inside rounds 1..10, else RCON lookup is meaningless
	step_round_valid: assert property (@(posedge clk) disable iff (reset)
		step |-> (round != '0 && round <= aes_pkg::round_t'(aes_pkg::NUM_ROUNDS)))
		else $error("key step outside a valid round");

endmodule

// File: source/aes_pkg.sv
////////////////////////////////////////
// AES-128 only (Nk = 4, Nb = 4, Nr = 10)
// blocks are column-major bytes as in FIPS-197
////////////////////////////////////////

package aes_pkg;

	// widths
	localparam int BLOCK_BITS = 128;
	localparam int WORD_BITS = 32;
	localparam int NUM_ROUNDS = 10;
	localparam int ROUND_BITS = 4;

	// start edge to done: one capture, two cycles per round, one final add
	localparam int CORE_LATENCY = 2 * NUM_ROUNDS + 2;

	typedef logic [BLOCK_BITS-1:0] block_t;
	typedef logic [WORD_BITS-1:0] word_t;
	typedef logic [7:0] byte_t;
	typedef logic [ROUND_BITS-1:0] round_t;

	// round constants, index is the round being computed
	localparam word_t RCON [1:NUM_ROUNDS] = '{
		32'h01000000, 32'h02000000, 32'h04000000, 32'h08000000, 32'h10000000,
		32'h20000000, 32'h40000000, 32'h80000000, 32'h1b000000, 32'h36000000
	};

	////////////////////////////////////////
	// GF(2^8) arithmetic, poly x^8+x^4+x^3+x+1
	////////////////////////////////////////

	// multiply by x: shift left, reduce on overflow
	function automatic byte_t gf_xtime(byte_t a);
		return a[7] ? ({a[6:0], 1'b0} ^ 8'h1b) : {a[6:0], 1'b0};
	endfunction

	// shift-and-add multiply, one partial product per bit of b
	function automatic byte_t gf_mul(byte_t a, byte_t b);
		byte_t acc;
		byte_t sh;
		acc = '0;
		sh = a;
		for (int i = 0; i < 8; i++) begin
			if (b[i])
				acc = acc ^ sh;
			sh = gf_xtime(sh);
		end
		return acc;
	endfunction

endpackage

// File: source/aes_round.sv
////////////////////////////////////////
// iterative cipher state, one round per step
// ciphertext register is only written on done_load
////////////////////////////////////////

module aes_round (
	input logic clk,
	input logic reset,
	input logic capture,
	input logic step,
	input logic last_round,
	input aes_pkg::block_t plaintext,
	input aes_pkg::block_t round_key,
	output aes_pkg::block_t ciphertext,
	input logic done_load
);

	aes_pkg::block_t state;
	aes_pkg::block_t add_key;
	aes_pkg::block_t sub_state;
	aes_pkg::block_t shifted;
	aes_pkg::block_t mixed;

	////////////////////////////////////////
	// round functions
	////////////////////////////////////////

	// byte (row r, col c) sits at bits 127-8*(4c+r)
	// row r rotates left by r columns
	function automatic aes_pkg::block_t shift_rows(aes_pkg::block_t s);
		aes_pkg::block_t y;
		y = '0;
		for (int c = 0; c < 4; c++) begin
			for (int r = 0; r < 4; r++)
				y[127 - 8*(4*c + r) -: 8] = s[127 - 8*(4*((c + r) % 4) + r) -: 8];
		end
		return y;
	endfunction

	// one column; 2a0 ^ 3a1 ^ a2 ^ a3 folded into xtime of a pair plus the column sum
	function automatic aes_pkg::word_t mix_column(aes_pkg::word_t w);
		aes_pkg::byte_t a0;
		aes_pkg::byte_t a1;
		aes_pkg::byte_t a2;
		aes_pkg::byte_t a3;
		aes_pkg::byte_t sum;
		{a0, a1, a2, a3} = w;
		sum = a0 ^ a1 ^ a2 ^ a3;
		return {a0 ^ sum ^ aes_pkg::gf_xtime(a0 ^ a1),
			a1 ^ sum ^ aes_pkg::gf_xtime(a1 ^ a2),
			a2 ^ sum ^ aes_pkg::gf_xtime(a2 ^ a3),
			a3 ^ sum ^ aes_pkg::gf_xtime(a3 ^ a0)};
	endfunction

	// AddRoundKey feeds SubBytes
	assign add_key = state ^ round_key;

	aes_sbox #(
		.NUM_BYTES(16)
	) i_sbox (
		.clk(clk),
		.in_bytes(add_key),
		.out_bytes(sub_state)
	);

	assign shifted = shift_rows(sub_state);

	always_comb begin
		for (int c = 0; c < 4; c++)
			mixed[127 - 32*c -: 32] = mix_column(shifted[127 - 32*c -: 32]);
	end

	////////////////////////////////////////
	// registers
	////////////////////////////////////////

	// state, MixColumns skipped in round 10
	always_ff @(posedge clk) begin
		if (capture)
			state <= plaintext;
		else if (step)
			state <= last_round ? shifted : mixed;
	end

	// final AddRoundKey with the round-10 key
	always_ff @(posedge clk) begin
		if (done_load)
			ciphertext <= add_key;
	end

	// a restart in the middle of a round would corrupt the state
	capture_step_excl: assert property (@(posedge clk) disable iff (reset) !(capture && step))
		else $error("capture and step in the same cycle");

endmodule

// File: source/aes_sbox.sv
////////////////////////////////////////
// registered S-box bank, one clk of latency
// output follows input every cycle, no enable
////////////////////////////////////////

module aes_sbox #(
	parameter int NUM_BYTES = 4
) (
	input logic clk,
	input aes_pkg::byte_t [NUM_BYTES-1:0] in_bytes,
	output aes_pkg::byte_t [NUM_BYTES-1:0] out_bytes
);

	aes_pkg::byte_t [NUM_BYTES-1:0] sub_bytes;

	// multiplicative inverse as a^254
	// zero comes out as zero on its own
	function automatic aes_pkg::byte_t gf_inv(aes_pkg::byte_t a);
		aes_pkg::byte_t sq;
		aes_pkg::byte_t inv;
		sq = a;
		inv = 8'h01;
		// square-and-multiply over exponents 2, 4, ... 128
		for (int i = 0; i < 7; i++) begin
			sq = aes_pkg::gf_mul(sq, sq);
			inv = aes_pkg::gf_mul(inv, sq);
		end
		return inv;
	endfunction

	// FIPS-197 affine map
	// b = x ^ rotl1 ^ rotl2 ^ rotl3 ^ rotl4 ^ 0x63
	function automatic aes_pkg::byte_t affine(aes_pkg::byte_t x);
		aes_pkg::byte_t b;
		b = x;
		b = b ^ {x[6:0], x[7]};
		b = b ^ {x[5:0], x[7:6]};
		b = b ^ {x[4:0], x[7:5]};
		b = b ^ {x[3:0], x[7:4]};
		return b ^ 8'h63;
	endfunction

	// substitution for the whole bank
	always_comb begin
		for (int i = 0; i < NUM_BYTES; i++)
			sub_bytes[i] = affine(gf_inv(in_bytes[i]));
	end

	// output register, block-RAM style lookup timing
	always_ff @(posedge clk) begin
		out_bytes <= sub_bytes;
	end

endmodule

// File: source/aes_spi.sv
////////////////////////////////////////
// SPI mode 0, MSB first; sck unrelated to clk
// keep sck idle while the core runs
////////////////////////////////////////

module aes_spi (
	input logic sck,
	input logic sdi,
	input logic load,
	input logic done,
	input aes_pkg::block_t ciphertext,
	output aes_pkg::block_t plaintext,
	output aes_pkg::block_t key,
	output logic sdo
);

	aes_pkg::block_t captured;
	// done as seen at the last falling sck
	logic was_done;
	logic sdo_next;

	// 256-bit input shift, plaintext goes in first so it ends up on top
	always_ff @(posedge sck) begin
		if (load)
			{plaintext, key} <= {plaintext[aes_pkg::BLOCK_BITS-2:0], key, sdi};
	end

	// first read edge grabs the ciphertext, later edges shift it
	always_ff @(posedge sck) begin
		if (!was_done)
			captured <= ciphertext;
		else
			captured <= {captured[aes_pkg::BLOCK_BITS-2:0], 1'b0};
	end

	// sdo moves half a period after the read edge
	// bit 126 here because bit 127 was shown directly
	always_ff @(negedge sck) begin
		was_done <= done;
		sdo_next <= captured[aes_pkg::BLOCK_BITS-2];
	end

	// MSB is presented before the first read edge
	assign sdo = (done && !was_done) ? ciphertext[aes_pkg::BLOCK_BITS-1] : sdo_next;

endmodule

// File: verification/aes_vectors.svh
////////////////////////////////////////
// known-answer vectors for AES-128 encrypt
// included inside the testbench module
////////////////////////////////////////

`ifndef aes_vectors_svh
`define aes_vectors_svh

// number of entries in the table
localparam int vector_count = 3;

// columns: key, plaintext, expected ciphertext
// all blocks MSB first, bytes in FIPS-197 order

// cipher key per entry
localparam aes_pkg::block_t vector_key [vector_count] = '{
	// FIPS-197 appendix B
	128'h2b7e151628aed2a6abf7158809cf4f3c,
	// FIPS-197 appendix C.1
	128'h000102030405060708090a0b0c0d0e0f,
	// all zero
	128'h00000000000000000000000000000000
};

// plaintext per entry, shifted in ahead of the key
localparam aes_pkg::block_t vector_plain [vector_count] = '{
	128'h3243f6a8885a308d313198a2e0370734,
	128'h00112233445566778899aabbccddeeff,
	128'h00000000000000000000000000000000
};

// published ciphertext per entry
localparam aes_pkg::block_t vector_cipher [vector_count] = '{
	128'h3925841d02dc09fbdc118597196a0b32,
	128'h69c4e0d86a7b0430d8cdb78070b4c55a,
	128'h66e94bd4ef8a2c3b884cfa59ca342b2e
};

`endif

// File: verification/aes_tb.sv
////////////////////////////////////////
// sck runs at a quarter of clk, idle low
// vectors go back to back through the serial port
////////////////////////////////////////

module aes_tb;

	`include "aes_vectors.svh"

	logic clk = 1'b0;
	logic reset;
	logic sck;
	logic sdi;
	logic load;
	logic sdo;
	logic done;

	aes i_dut (
		.clk(clk),
		.reset(reset),
		.sck(sck),
		.sdi(sdi),
		.load(load),
		.sdo(sdo),
		.done(done)
	);

	// period 10
	always #5 clk = ~clk;

	////////////////////////////////////////
	// helpers
	////////////////////////////////////////

	// stop at the first mismatch
	task automatic compare(input logic [127:0] actual, input logic [127:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("Error at time %0t: %s, got %0h, expected %0h",
				$time, what, actual, expected);
			$display("Simulation failed");
			$fatal(1, "value mismatch");
		end
	endtask

	// n falling clk edges, done must sit at level on each one
	task automatic wait_with_done(input logic level, input int clks);
		for (int i = 0; i < clks; i++) begin
			@(negedge clk);
			compare(128'(done), 128'(level),
				level ? "done held high before load rises" : "done low during load");
		end
	endtask

	// plaintext then key, MSB first, one bit per sck period
	// two clk low then two clk high per bit
	task automatic shift_in_block(input aes_pkg::block_t plaintext,
		input aes_pkg::block_t key);
		logic [255:0] stream;
		stream = {plaintext, key};
		@(negedge clk);
		load = 1'b1;
		for (int i = 255; i >= 0; i--) begin
			sdi = stream[i];
			sck = 1'b0;
			wait_with_done(1'b0, 2);
			sck = 1'b1;
			wait_with_done(1'b0, 2);
		end
		// sck back to idle before load drops, sdi left stable
		sck = 1'b0;
		wait_with_done(1'b0, 2);
		load = 1'b0;
	endtask

	// load fell on the last falling edge; count rising edges after the start edge
	task automatic wait_for_done();
		int cycles;
		// next rising edge is the one that first sees load low
		@(negedge clk);
		compare(128'(done), 128'(0), "done low at the start edge");
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
		end while (!done && cycles < 2 * aes_pkg::CORE_LATENCY);
		compare(128'(cycles), 128'(aes_pkg::CORE_LATENCY), "clk edges from start to done");
	endtask

	// bit 127 must already be there before the first rising sck
	// later bits are sampled with sck low, after sdo moved on the falling sck
	task automatic read_block(input aes_pkg::block_t expected);
		for (int i = 127; i >= 0; i--) begin
			compare(128'(sdo), 128'(expected[i]), $sformatf("ciphertext bit %0d on sdo", i));
			sck = 1'b1;
			wait_with_done(1'b1, 2);
			sck = 1'b0;
			wait_with_done(1'b1, 2);
		end
	endtask

	////////////////////////////////////////
	// watchdog
	////////////////////////////////////////

	// per block: 256 bits in and 128 out at 4 clk each, the core run, slack
	initial begin
		#((vector_count * (384 * 4 + aes_pkg::CORE_LATENCY + 100) + 20) * 10);
		$display("Timeout: the test did not finish in the expected number of cycles");
		$display("Simulation failed");
		$fatal(1, "watchdog expired");
	end

	////////////////////////////////////////
	// test sequence
	////////////////////////////////////////

	initial begin
		reset = 1'b1;
		sck = 1'b0;
		sdi = 1'b0;
		load = 1'b0;

		// reset over three rising edges, released on a falling edge
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		@(negedge clk);
		compare(128'(done), 128'(0), "done low after reset");

		// no reset between entries, so state must not leak across blocks
		for (int v = 0; v < vector_count; v++) begin
			shift_in_block(vector_plain[v], vector_key[v]);
			wait_for_done();
			read_block(vector_cipher[v]);
		end

		$display("Simulation passed");
		$finish;
	end

endmodule
